//--- Makefile
# Verilator flow for the line fetcher
VERILATOR  = verilator
TOP        = tb_line_fetcher
RTL_TOP    = line_fetcher
FILELIST   = all.f
OBJ_DIR    = obj_dir
COMMON     = --timing --timescale 1ns/1ns
LINT_FLAGS = --lint-only $(COMMON)
SIM_FLAGS  = --binary --assert -j 0 $(COMMON)
PASS_MSG   = Simulation finished: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

# Passes only when the pass line appears in the output
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- all.f
logic/lcd_ctrl_pkg.sv
logic/vram_map_pkg.sv
logic/fetch_control.sv
logic/map_address.sv
logic/pattern_address.sv
logic/vram_port.sv
logic/row_push.sv
logic/line_fetcher.sv
test/vram_model.sv
test/tb_line_fetcher.sv

//--- logic/fetch_control.sv
// Register inputs must stay constant while busy; start is ignored until the line is done
`timescale 1ns/1ns

module fetch_control
    import lcd_ctrl_pkg::*, vram_map_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       start,
    input  logic       read_done,
    input  logic       push_done,
    output logic       read_start,
    output logic [1:0] read_sel,
    output logic       capture_low,
    output logic       capture_high,
    output logic [4:0] tile_col,
    output logic       push_start,
    output logic       busy,
    output logic       done
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_MAP_RD,
        ST_LOW_RD,
        ST_HIGH_RD,
        ST_PUSH,
        ST_NEXT
    } state_t;

    state_t state;

    // Select follows the state so it is valid on read_start and read_done
    always_comb begin
        case (state)
            ST_LOW_RD:  read_sel = SEL_LOW;
            ST_HIGH_RD: read_sel = SEL_HIGH;
            default:    read_sel = SEL_MAP;
        endcase
    end

    // Plane bytes are valid in read_data on the read_done cycle
    assign capture_low  = read_done && (state == ST_LOW_RD);
    assign capture_high = read_done && (state == ST_HIGH_RD);

    //////////////////////////////////////////////////////////////////////
    // Line sequencer
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= ST_IDLE;
            tile_col   <= '0;
            read_start <= 1'b0;
            push_start <= 1'b0;
            busy       <= 1'b0;
            done       <= 1'b0;
        end else begin
            read_start <= 1'b0;
            push_start <= 1'b0;
            done       <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (start) begin
                        busy       <= 1'b1;
                        tile_col   <= '0;
                        read_start <= 1'b1;
                        state      <= ST_MAP_RD;
                    end
                end
                ST_MAP_RD: begin
                    if (read_done) begin
                        read_start <= 1'b1;
                        state      <= ST_LOW_RD;
                    end
                end
                ST_LOW_RD: begin
                    if (read_done) begin
                        read_start <= 1'b1;
                        state      <= ST_HIGH_RD;
                    end
                end
                ST_HIGH_RD: begin
                    if (read_done) begin
                        push_start <= 1'b1;
                        state      <= ST_PUSH;
                    end
                end
                // Next tile waits for the hand-off, so back-pressure stalls the line
                ST_PUSH: begin
                    if (push_done) begin
                        if (tile_col == 5'(TILES_PER_LINE - 1)) begin
                            done  <= 1'b1;
                            busy  <= 1'b0;
                            state <= ST_IDLE;
                        end else begin
                            state <= ST_NEXT;
                        end
                    end
                end
                ST_NEXT: begin
                    tile_col   <= tile_col + 5'd1;
                    read_start <= 1'b1;
                    state      <= ST_MAP_RD;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Column counter stays inside the line for as long as the line runs
    a_col_in_range: assert property (@(posedge clk) disable iff (reset)
        busy |-> tile_col < 5'(TILES_PER_LINE));

endmodule

//--- logic/lcd_ctrl_pkg.sv
// LCDC bit positions and screen geometry for coarse scrolling only; one line is 20 tile columns
package lcd_ctrl_pkg;

    //////////////////////////////////////////////////////////////////////
    // LCDC bit positions
    //////////////////////////////////////////////////////////////////////

    // Background blanking when clear
    localparam int LCDC_BG_ENABLE   = 0;
    // Background tile map 0x9800 or 0x9C00
    localparam int LCDC_BG_MAP_SEL  = 3;
    // Tile data unsigned from 0x8000 when set, signed around 0x9000 when clear
    localparam int LCDC_TILE_MODE   = 4;
    localparam int LCDC_WIN_ENABLE  = 5;
    // Window tile map 0x9800 or 0x9C00
    localparam int LCDC_WIN_MAP_SEL = 6;

    //////////////////////////////////////////////////////////////////////
    // Screen geometry
    //////////////////////////////////////////////////////////////////////

    localparam int TILES_PER_LINE  = 20;
    localparam int PIXELS_PER_TILE = 8;
    // WX holds the window left edge plus 7
    localparam int WIN_X_OFFSET    = 7;
    // Tiles per row of a tile map
    localparam int MAP_WIDTH       = 32;

endpackage

//--- logic/line_fetcher.sv
// Background and window only, no sprites or fine scroll; registers are sampled throughout the line
`timescale 1ns/1ns

module line_fetcher
    import lcd_ctrl_pkg::*, vram_map_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       start,
    input  logic [7:0] lcdc,
    input  logic [7:0] scx,
    input  logic [7:0] scy,
    input  logic [7:0] ly,
    input  logic [7:0] wx,
    input  logic [7:0] wy,
    output logic       busy,
    output logic       done,
    output logic       vram_req,
    output vram_addr_t vram_addr,
    input  logic       vram_ack,
    input  logic [7:0] vram_data,
    output logic       row_req,
    output pixel_row_t row_pixels,
    input  logic       row_ack
);

    logic        read_start;
    logic        read_done;
    logic [1:0]  read_sel;
    logic [7:0]  read_data;
    logic        capture_low;
    logic        capture_high;
    logic        push_start;
    logic        push_done;
    logic [4:0]  tile_col;
    logic [2:0]  fine_row;
    vram_addr_t  map_addr;
    vram_addr_t  plane_addr;
    vram_addr_t  read_addr;
    tile_index_t tile_index;

    // Map byte kept for both plane reads, since read_data is reused
    always_ff @(posedge clk) begin
        if (read_done && read_sel == SEL_MAP) begin
            tile_index <= read_data;
        end
    end

    always_comb begin
        case (read_sel)
            SEL_LOW:  read_addr = plane_addr;
            SEL_HIGH: read_addr = plane_addr + vram_addr_t'(1);
            default:  read_addr = map_addr;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // Control and datapath
    //////////////////////////////////////////////////////////////////////

    fetch_control u_fetch_control (
        .clk          (clk),
        .reset        (reset),
        .start        (start),
        .read_done    (read_done),
        .push_done    (push_done),
        .read_start   (read_start),
        .read_sel     (read_sel),
        .capture_low  (capture_low),
        .capture_high (capture_high),
        .tile_col     (tile_col),
        .push_start   (push_start),
        .busy         (busy),
        .done         (done)
    );

    map_address u_map_address (
        .lcdc     (lcdc),
        .scx      (scx),
        .scy      (scy),
        .ly       (ly),
        .wx       (wx),
        .wy       (wy),
        .tile_col (tile_col),
        .map_addr (map_addr),
        .fine_row (fine_row)
    );

    pattern_address u_pattern_address (
        .tile_index (tile_index),
        .lcdc       (lcdc),
        .fine_row   (fine_row),
        .plane_addr (plane_addr)
    );

    vram_port u_vram_port (
        .clk        (clk),
        .reset      (reset),
        .read_start (read_start),
        .read_addr  (read_addr),
        .read_done  (read_done),
        .read_data  (read_data),
        .vram_req   (vram_req),
        .vram_addr  (vram_addr),
        .vram_ack   (vram_ack),
        .vram_data  (vram_data)
    );

    row_push u_row_push (
        .clk          (clk),
        .reset        (reset),
        .capture_low  (capture_low),
        .capture_high (capture_high),
        .plane_data   (read_data),
        .bg_enable    (lcdc[LCDC_BG_ENABLE]),
        .push_start   (push_start),
        .push_done    (push_done),
        .row_req      (row_req),
        .row_pixels   (row_pixels),
        .row_ack      (row_ack)
    );

endmodule

//--- logic/map_address.sv
// Coarse scroll only, SCX bits 2:0 are ignored; window rows count from WY with no line counter
`timescale 1ns/1ns

module map_address
    import lcd_ctrl_pkg::*, vram_map_pkg::*;
(
    input  logic [7:0] lcdc,
    input  logic [7:0] scx,
    input  logic [7:0] scy,
    input  logic [7:0] ly,
    input  logic [7:0] wx,
    input  logic [7:0] wy,
    input  logic [4:0] tile_col,
    output vram_addr_t map_addr,
    output logic [2:0] fine_row
);

    logic [7:0] screen_x;
    logic [8:0] win_dx;
    logic       in_window;
    logic [7:0] map_row;
    logic [4:0] map_col;
    vram_addr_t map_base;

    always_comb begin
        screen_x  = 8'(tile_col) * 8'(PIXELS_PER_TILE);
        // Nine bits, so a WX below 7 puts the edge left of column 0
        win_dx    = {1'b0, screen_x} + 9'(WIN_X_OFFSET) - {1'b0, wx};
        in_window = lcdc[LCDC_WIN_ENABLE] && (ly >= wy) && !win_dx[8];

        if (in_window) begin
            map_row  = ly - wy;
            map_col  = win_dx[7:3];
            map_base = lcdc[LCDC_WIN_MAP_SEL] ? MAP_BASE_HIGH : MAP_BASE_LOW;
        end else begin
            // Both wrap around the 32x32 map
            map_row  = scy + ly;
            map_col  = scx[7:3] + tile_col;
            map_base = lcdc[LCDC_BG_MAP_SEL] ? MAP_BASE_HIGH : MAP_BASE_LOW;
        end

        map_addr = map_base + vram_addr_t'(map_row[7:3]) * vram_addr_t'(MAP_WIDTH)
                 + vram_addr_t'(map_col);
        fine_row = map_row[2:0];
    end

endmodule

//--- logic/pattern_address.sv
// Gives the low bit-plane address only; the high plane is the next byte up
`timescale 1ns/1ns

module pattern_address
    import lcd_ctrl_pkg::*, vram_map_pkg::*;
(
    input  tile_index_t tile_index,
    input  logic [7:0]  lcdc,
    input  logic [2:0]  fine_row,
    output vram_addr_t  plane_addr
);

    vram_addr_t tile_base;
    vram_addr_t tile_offset;

    always_comb begin
        if (lcdc[LCDC_TILE_MODE]) begin
            tile_base   = TILE_BASE_UNSIGNED;
            tile_offset = vram_addr_t'(tile_index.unsigned_idx) * vram_addr_t'(BYTES_PER_TILE);
        end else begin
            // Sign-extended, so indices 0x80..0xFF land in 0x8800..0x8FF0
            tile_base   = TILE_BASE_SIGNED;
            tile_offset = vram_addr_t'(tile_index.signed_idx) * vram_addr_t'(BYTES_PER_TILE);
        end

        plane_addr = tile_base + tile_offset
                   + vram_addr_t'(fine_row) * vram_addr_t'(BYTES_PER_ROW);
    end

endmodule

//--- logic/row_push.sv
// Holds one tile row; planes must not be recaptured until push_done
`timescale 1ns/1ns

module row_push
    import lcd_ctrl_pkg::*, vram_map_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       capture_low,
    input  logic       capture_high,
    input  logic [7:0] plane_data,
    input  logic       bg_enable,
    input  logic       push_start,
    output logic       push_done,
    output logic       row_req,
    output pixel_row_t row_pixels,
    input  logic       row_ack
);

    typedef enum logic [1:0] {
        RP_IDLE,
        RP_REQ,
        RP_RELEASE
    } push_state_t;

    push_state_t state;
    logic [7:0]  plane_low;
    logic [7:0]  plane_high;
    pixel_row_t  next_row;

    // Plane bit 7 is the leftmost pixel
    always_comb begin
        for (int i = 0; i < PIXELS_PER_TILE; i++) begin
            next_row[2*i +: 2] = {plane_high[i], plane_low[i]};
        end
    end

    always_ff @(posedge clk) begin
        if (capture_low) begin
            plane_low <= plane_data;
        end
        if (capture_high) begin
            plane_high <= plane_data;
        end
        if (state == RP_IDLE && push_start) begin
            row_pixels <= bg_enable ? next_row : '0;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Four-phase hand-off to the pixel queue
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= RP_IDLE;
            row_req   <= 1'b0;
            push_done <= 1'b0;
        end else begin
            push_done <= 1'b0;
            case (state)
                RP_IDLE: begin
                    if (push_start) begin
                        row_req <= 1'b1;
                        state   <= RP_REQ;
                    end
                end
                RP_REQ: begin
                    if (row_ack) begin
                        row_req <= 1'b0;
                        state   <= RP_RELEASE;
                    end
                end
                RP_RELEASE: begin
                    if (!row_ack) begin
                        push_done <= 1'b1;
                        state     <= RP_IDLE;
                    end
                end
                default: state <= RP_IDLE;
            endcase
        end
    end

    a_row_stable: assert property (@(posedge clk) disable iff (reset)
        row_req && $past(row_req) |-> $stable(row_pixels));

endmodule

//--- logic/vram_map_pkg.sv
// Video memory layout for the 0x8000-0x9FFF window; addresses are 16-bit CPU-side values
package vram_map_pkg;

    typedef logic [15:0] vram_addr_t;

    //////////////////////////////////////////////////////////////////////
    // Region bases and tile sizes
    //////////////////////////////////////////////////////////////////////

    localparam vram_addr_t MAP_BASE_LOW       = 16'h9800;
    localparam vram_addr_t MAP_BASE_HIGH      = 16'h9C00;
    localparam vram_addr_t TILE_BASE_UNSIGNED = 16'h8000;
    localparam vram_addr_t TILE_BASE_SIGNED   = 16'h9000;

    // Eight rows of two bit-plane bytes
    localparam int BYTES_PER_TILE = 16;
    localparam int BYTES_PER_ROW  = 2;

    // Source of the current read
    localparam logic [1:0] SEL_MAP  = 2'd0;
    localparam logic [1:0] SEL_LOW  = 2'd1;
    localparam logic [1:0] SEL_HIGH = 2'd2;

    // Tile map entry, taken as 0..255 or -128..127 depending on LCDC bit 4
    typedef union packed {
        logic [7:0]        unsigned_idx;
        logic signed [7:0] signed_idx;
    } tile_index_t;

    // Eight 2-bit color indices, leftmost pixel in bits 15:14
    typedef logic [15:0] pixel_row_t;

endpackage

//--- logic/vram_port.sv
// One read at a time; read_start is ignored while a read is pending
`timescale 1ns/1ns

module vram_port
    import vram_map_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       read_start,
    input  vram_addr_t read_addr,
    output logic       read_done,
    output logic [7:0] read_data,
    output logic       vram_req,
    output vram_addr_t vram_addr,
    input  logic       vram_ack,
    input  logic [7:0] vram_data
);

    typedef enum logic [1:0] {
        VP_IDLE,
        VP_REQ,
        VP_RELEASE
    } port_state_t;

    port_state_t state;

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= VP_IDLE;
            vram_req  <= 1'b0;
            read_done <= 1'b0;
        end else begin
            read_done <= 1'b0;
            case (state)
                VP_IDLE: begin
                    if (read_start) begin
                        vram_req <= 1'b1;
                        state    <= VP_REQ;
                    end
                end
                VP_REQ: begin
                    if (vram_ack) begin
                        vram_req <= 1'b0;
                        state    <= VP_RELEASE;
                    end
                end
                // Done only once the memory has dropped its ack
                VP_RELEASE: begin
                    if (!vram_ack) begin
                        read_done <= 1'b1;
                        state     <= VP_IDLE;
                    end
                end
                default: state <= VP_IDLE;
            endcase
        end
    end

    // Address and data holding registers
    always_ff @(posedge clk) begin
        if (state == VP_IDLE && read_start) begin
            vram_addr <= read_addr;
        end
        if (state == VP_REQ && vram_ack) begin
            read_data <= vram_data;
        end
    end

    a_addr_stable: assert property (@(posedge clk) disable iff (reset)
        vram_req && $past(vram_req) |-> $stable(vram_addr));

endmodule

//--- test/tb_line_fetcher.sv
// Registers change only between lines; expected rows assume the same address rule as the memory model
`timescale 1ns/1ns

module tb_line_fetcher
    import lcd_ctrl_pkg::*, vram_map_pkg::*;
();

    localparam int LINE_CYCLES     = TILES_PER_LINE * 60;
    localparam int WATCHDOG_CYCLES = 10 + 20 * LINE_CYCLES;

    logic       clk;
    logic       reset;
    logic       start;
    logic [7:0] lcdc;
    logic [7:0] scx;
    logic [7:0] scy;
    logic [7:0] ly;
    logic [7:0] wx;
    logic [7:0] wy;
    logic       busy;
    logic       done;
    logic       vram_req;
    vram_addr_t vram_addr;
    logic       vram_ack;
    logic [7:0] vram_data;
    logic       row_req;
    pixel_row_t row_pixels;
    logic       row_ack;

    int          rows_seen = 0;
    int          done_seen = 0;
    int          row_errors = 0;
    int          protocol_errors = 0;
    logic [31:0] reg_seed = 32'd5;
    logic [31:0] ack_seed = 32'd5;

    line_fetcher u_line_fetcher (
        .clk        (clk),
        .reset      (reset),
        .start      (start),
        .lcdc       (lcdc),
        .scx        (scx),
        .scy        (scy),
        .ly         (ly),
        .wx         (wx),
        .wy         (wy),
        .busy       (busy),
        .done       (done),
        .vram_req   (vram_req),
        .vram_addr  (vram_addr),
        .vram_ack   (vram_ack),
        .vram_data  (vram_data),
        .row_req    (row_req),
        .row_pixels (row_pixels),
        .row_ack    (row_ack)
    );

    vram_model u_vram_model (
        .clk       (clk),
        .vram_req  (vram_req),
        .vram_addr (vram_addr),
        .vram_ack  (vram_ack),
        .vram_data (vram_data)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [7:0] mem_byte(input logic [15:0] addr);
        return addr[7:0] ^ addr[15:8] ^ 8'h5A;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Reference model of one tile row
    //////////////////////////////////////////////////////////////////////

    function automatic pixel_row_t expected_row(input logic [7:0] r_lcdc, input logic [7:0] r_scx,
                                                input logic [7:0] r_scy, input logic [7:0] r_ly,
                                                input logic [7:0] r_wx, input logic [7:0] r_wy,
                                                input int col);
        int          left_x;
        logic        win;
        int          map_row;
        int          map_col;
        logic [15:0] base;
        logic [15:0] entry;
        logic [7:0]  idx;
        logic [15:0] plane;
        logic [7:0]  low;
        logic [7:0]  high;
        pixel_row_t  row;
        left_x = col * 8;
        win = r_lcdc[LCDC_WIN_ENABLE] && (r_ly >= r_wy) && (left_x + 7 >= int'(r_wx));
        if (win) begin
            map_row = int'(r_ly) - int'(r_wy);
            map_col = (left_x + 7 - int'(r_wx)) / 8;
            base    = r_lcdc[LCDC_WIN_MAP_SEL] ? 16'h9C00 : 16'h9800;
        end else begin
            map_row = (int'(r_scy) + int'(r_ly)) % 256;
            map_col = (int'(r_scx) / 8 + col) % 32;
            base    = r_lcdc[LCDC_BG_MAP_SEL] ? 16'h9C00 : 16'h9800;
        end
        entry = base + 16'((map_row / 8) * 32 + map_col);
        idx   = mem_byte(entry);
        // Signed mode puts 0x80..0xFF below 0x9000
        if (r_lcdc[LCDC_TILE_MODE]) begin
            plane = 16'h8000 + 16'(int'(idx) * 16);
        end else begin
            plane = 16'(32'sh9000 + int'($signed(idx)) * 16);
        end
        plane = plane + 16'((map_row % 8) * 2);
        low   = mem_byte(plane);
        high  = mem_byte(plane + 16'd1);
        row   = '0;
        if (r_lcdc[LCDC_BG_ENABLE]) begin
            for (int p = 0; p < 8; p++) begin
                row[15 - 2*p] = high[7 - p];
                row[14 - 2*p] = low[7 - p];
            end
        end
        return row;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Stimulus tasks
    //////////////////////////////////////////////////////////////////////

    task automatic pick_scroll();
        reg_seed = xorshift(reg_seed);
        scx = reg_seed[7:0];
        scy = reg_seed[15:8];
        ly  = 8'(reg_seed[31:16] % 16'd144);
    endtask

    task automatic pick_window();
        reg_seed = xorshift(reg_seed);
        wx = 8'(reg_seed[15:0] % 16'd167);
        wy = 8'(reg_seed[31:16] % 16'd144);
    endtask

    // Called 2 ns after an edge to start one line and wait for done
    task automatic run_line(input logic [7:0] line_lcdc);
        int waited;
        lcdc      = line_lcdc;
        rows_seen = 0;
        done_seen = 0;
        start     = 1'b1;
        @(posedge clk);
        #2;
        start = 1'b0;
        assert (busy) else begin
            protocol_errors++;
            $display("busy did not rise one cycle after start");
        end
        waited = 0;
        while (!done && waited < LINE_CYCLES) begin
            @(posedge clk);
            #2;
            waited++;
        end
        assert (done) else begin
            protocol_errors++;
            $display("No done pulse within %0d cycles of start", LINE_CYCLES);
        end
        assert (!busy) else begin
            protocol_errors++;
            $display("busy still high at the end of the line");
        end
        @(posedge clk);
        #2;
        assert (rows_seen == TILES_PER_LINE) else begin
            protocol_errors++;
            $display("Line ended with %0d rows instead of %0d", rows_seen, TILES_PER_LINE);
        end
        assert (done_seen == 1) else begin
            protocol_errors++;
            $display("Expected one done pulse for the line but saw %0d", done_seen);
        end
    endtask

    initial begin : clock_gen
        clk = 1'b0;
        forever begin
            #10;
            clk = ~clk;
        end
    end

    // Pixel queue side with an ack delay of 0..5 cycles
    initial begin : row_acknowledger
        int delay;
        row_ack = 1'b0;
        forever begin
            @(posedge clk);
            #2;
            if (row_req && !row_ack) begin
                ack_seed = xorshift(ack_seed);
                delay    = int'(ack_seed % 32'd6);
                repeat (delay) begin
                    @(posedge clk);
                    #2;
                end
                row_ack = 1'b1;
                do begin
                    @(posedge clk);
                    #2;
                end while (row_req);
                row_ack = 1'b0;
            end
        end
    end

    // Sampled 1 ns after the edge before any input changes
    initial begin : row_checker
        logic       req_before;
        pixel_row_t want;
        req_before = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            if (row_req && !req_before) begin
                assert (rows_seen < TILES_PER_LINE) else begin
                    protocol_errors++;
                    $display("Extra row offered after the last column of the line");
                end
                want = expected_row(lcdc, scx, scy, ly, wx, wy, rows_seen);
                assert (row_pixels == want) else begin
                    row_errors++;
                    $display("ERROR row_pixels column %0d expected 0x%04h actual 0x%04h",
                             rows_seen, want, row_pixels);
                end
                rows_seen++;
            end
            if (done) begin
                done_seen++;
            end
            req_before = row_req;
        end
    end

    // Address and row must hold while their request is up
    initial begin : handshake_monitor
        logic       vram_req_before;
        logic       row_req_before;
        vram_addr_t addr_before;
        pixel_row_t pixels_before;
        vram_req_before = 1'b0;
        row_req_before  = 1'b0;
        addr_before     = '0;
        pixels_before   = '0;
        forever begin
            @(posedge clk);
            #1;
            if (vram_req && vram_req_before) begin
                assert (vram_addr == addr_before) else begin
                    protocol_errors++;
                    $display("ERROR vram_addr changed under vram_req from 0x%04h to 0x%04h",
                             addr_before, vram_addr);
                end
            end
            if (row_req && row_req_before) begin
                assert (row_pixels == pixels_before) else begin
                    protocol_errors++;
                    $display("ERROR row_pixels changed under row_req from 0x%04h to 0x%04h",
                             pixels_before, row_pixels);
                end
            end
            // Reads of the next tile wait for the row hand-off
            assert (!(vram_req && row_req)) else begin
                protocol_errors++;
                $display("A video memory read was requested while a row was still offered");
            end
            vram_req_before = vram_req;
            row_req_before  = row_req;
            addr_before     = vram_addr;
            pixels_before   = row_pixels;
        end
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired after %0d cycles, the run did not complete", WATCHDOG_CYCLES);
        $display("Errors: %0d row mismatches, %0d protocol", row_errors, protocol_errors);
        $display("Simulation finished: FAIL");
        $finish;
    end

    //////////////////////////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////////////////////////

    initial begin : stimulus
        reset = 1'b1;
        start = 1'b0;
        lcdc  = 8'h00;
        scx   = 8'h00;
        scy   = 8'h00;
        ly    = 8'h00;
        wx    = 8'h00;
        wy    = 8'h00;
        repeat (10) @(posedge clk);
        #2;
        reset = 1'b0;
        assert (!busy && !done && !vram_req && !row_req) else begin
            protocol_errors++;
            $display("busy, done, vram_req or row_req was not low after reset");
        end

        // Unsigned tile data
        for (int n = 0; n < 3; n++) begin
            pick_scroll();
            run_line(8'h91);
        end
        // Signed tile data
        for (int n = 0; n < 3; n++) begin
            pick_scroll();
            run_line(8'h81);
        end
        // Background map base flips every line
        for (int n = 0; n < 4; n++) begin
            pick_scroll();
            run_line(n[0] ? 8'h91 : 8'h99);
        end
        // Window tests start with one line above WY and one with WY at zero
        for (int n = 0; n < 5; n++) begin
            pick_scroll();
            pick_window();
            if (n == 0) begin
                wy = ly + 8'd1;
            end
            if (n == 1) begin
                wy = 8'd0;
            end
            run_line(n[0] ? 8'hF1 : 8'hB1);
        end
        // Blanked background
        for (int n = 0; n < 2; n++) begin
            pick_scroll();
            run_line(8'h90);
        end

        $display("Errors: %0d row mismatches, %0d protocol", row_errors, protocol_errors);
        if (row_errors + protocol_errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

//--- test/vram_model.sv
// Read-only responder, every byte is addr[7:0] ^ addr[15:8] ^ 0x5A; ack delay 0..4 cycles
`timescale 1ns/1ns

module vram_model
    import vram_map_pkg::*;
(
    input  logic       clk,
    input  logic       vram_req,
    input  vram_addr_t vram_addr,
    output logic       vram_ack,
    output logic [7:0] vram_data
);

    logic [31:0] seed = 32'd5;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [7:0] byte_at(input vram_addr_t addr);
        return addr[7:0] ^ addr[15:8] ^ 8'h5A;
    endfunction

    // Four-phase slave, acts 2 ns after each rising edge
    initial begin : responder
        int delay;
        vram_ack  = 1'b0;
        vram_data = 8'h00;
        forever begin
            @(posedge clk);
            #2;
            if (vram_req && !vram_ack) begin
                seed  = xorshift(seed);
                delay = int'(seed % 32'd5);
                repeat (delay) begin
                    @(posedge clk);
                    #2;
                end
                vram_data = byte_at(vram_addr);
                vram_ack  = 1'b1;
                do begin
                    @(posedge clk);
                    #2;
                end while (vram_req);
                vram_ack = 1'b0;
            end
        end
    end

endmodule
